// ==== conv_acc_patterns.txt ====
# Columns: kind (W write, R read), hex address, hex data or expected read value
# A CTRL read that expects idle first waits for the engine
R 0000 00000004
R 0100 00000000
R 01FC 00000000
W 21E0 00000003
W 2910 00000005
W 3290 00100000
W 2034 0000FFFC
W 24D4 00000001
W 2294 00070000
W 2E84 00020000
W 0000 00000001
R 0000 00000006
R 0004 0000000F
R 0100 00100008
R 0104 00000000
R 0154 00090000
R 0150 00000000
R 0008 DEADBEEF
R 2000 DEADBEEF
R 0200 DEADBEEF
W 0000 00000001
R 0000 00000001
W 2E84 00630000
W 0000 00000001
R 0000 00000006
R 0154 00090000
R 0100 00100008

// ==== build.f ====
+incdir+.
conv_acc_pkg.sv
conv_acc_if.sv
psum_addr_gen.sv
psum_buffer.sv
acc_sequencer.sv
axil_regs.sv
conv_acc_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_conv_acc.sv

// ==== Bender.yml ====
package:
  name: conv_acc

export_include_dirs:
  - .

sources:
  - conv_acc_pkg.sv
  - conv_acc_if.sv
  - psum_addr_gen.sv
  - psum_buffer.sv
  - acc_sequencer.sv
  - axil_regs.sv
  - conv_acc_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_conv_acc.sv

// ==== tb_conv_acc.sv ====
`timescale 1ns/10ps
`include "conv_acc_macros.svh"

module tb_conv_acc import conv_acc_pkg::*; ();

    localparam int ZERO_WORDS = `CA_LEN_KIJ * `CA_LEN_NIJ * `CA_COL / 2;
    localparam int RUN_CYCLES = `CA_LEN_ONIJ * (`CA_LEN_KIJ * `CA_COL + 3);

    logic       s_axi_aclk;
    logic       s_axi_aresetn;
    axil_addr_t s_axi_awaddr;
    logic [2:0] s_axi_awprot;
    logic       s_axi_awvalid;
    logic       s_axi_awready;
    axil_data_t s_axi_wdata;
    logic [3:0] s_axi_wstrb;
    logic       s_axi_wvalid;
    logic       s_axi_wready;
    logic [1:0] s_axi_bresp;
    logic       s_axi_bvalid;
    logic       s_axi_bready;
    axil_addr_t s_axi_araddr;
    logic [2:0] s_axi_arprot;
    logic       s_axi_arvalid;
    logic       s_axi_arready;
    axil_data_t s_axi_rdata;
    logic [1:0] s_axi_rresp;
    logic       s_axi_rvalid;
    logic       s_axi_rready;

    // Expected read data handed to the checker
    logic       exp_valid;
    axil_addr_t exp_addr;
    axil_data_t exp_data;
    int         cycle_limit;
    logic       timed_out;
    int         rd_errors;
    int         wr_errors;
    int         rd_checks;

    integer     seed = 32'hc81dd5ca;
    int         misc_errors;
    int         reads_expected;
    logic [7:0] rec_kind [$];
    axil_addr_t rec_addr [$];
    axil_data_t rec_data [$];

    tb_clk_gen clk_i (.*);

    conv_acc_top dut_i (.*);

    tb_checker chk_i (.*);

    // ==============================
    // AXI-Lite transfers
    // ==============================
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        int stall;
        @(posedge s_axi_aclk);
        s_axi_awaddr  <= addr;
        s_axi_wdata   <= data;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        do begin
            @(negedge s_axi_aclk);
        end while (!s_axi_awready);
        @(posedge s_axi_aclk);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        do begin
            @(negedge s_axi_aclk);
        end while (!s_axi_bvalid);
        // Random back-pressure on the response
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) @(posedge s_axi_aclk);
        @(posedge s_axi_aclk);
        s_axi_bready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        int stall;
        @(posedge s_axi_aclk);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        do begin
            @(negedge s_axi_aclk);
        end while (!s_axi_arready);
        @(posedge s_axi_aclk);
        s_axi_arvalid <= 1'b0;
        do begin
            @(negedge s_axi_aclk);
        end while (!s_axi_rvalid);
        data  = s_axi_rdata;
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) @(posedge s_axi_aclk);
        @(posedge s_axi_aclk);
        s_axi_rready <= 1'b1;
        @(posedge s_axi_aclk);
        s_axi_rready <= 1'b0;
    endtask

    task automatic checked_read(input axil_addr_t addr, input axil_data_t expected);
        axil_data_t data;
        exp_addr  = addr;
        exp_data  = expected;
        exp_valid = 1'b1;
        axil_read(addr, data);
        exp_valid = 1'b0;
        reads_expected++;
    endtask

    // Poll CTRL until the idle bit is set
    task automatic wait_for_idle();
        axil_data_t status;
        do begin
            axil_read(`CA_ADDR_CTRL, status);
        end while (!status[2]);
    endtask

    // ==============================
    // Pattern file
    // ==============================
    task automatic load_patterns();
        int fd;
        int c;
        int n;
        axil_addr_t addr;
        axil_data_t data;
        fd = $fopen("conv_acc_patterns.txt", "r");
        if (fd == 0) begin
            $display("Pattern file conv_acc_patterns.txt could not be opened");
            misc_errors++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c == "W" || c == "R") begin
                n = $fscanf(fd, " %h %h", addr, data);
                if (n == 2) begin
                    rec_kind.push_back(8'(c));
                    rec_addr.push_back(addr);
                    rec_data.push_back(data);
                end else begin
                    $display("Pattern file holds a record that could not be parsed");
                    misc_errors++;
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic run_records();
        foreach (rec_kind[i]) begin
            if (rec_kind[i] == "W") begin
                axil_write(rec_addr[i], rec_data[i]);
            end else begin
                // A CTRL read expecting idle waits out a running pass first
                if (rec_addr[i] == `CA_ADDR_CTRL && rec_data[i][2]) begin
                    wait_for_idle();
                end
                checked_read(rec_addr[i], rec_data[i]);
            end
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int total;
        s_axi_awaddr   = '0;
        s_axi_awprot   = 3'b000;
        s_axi_awvalid  = 1'b0;
        s_axi_wdata    = '0;
        s_axi_wstrb    = 4'hF;
        s_axi_wvalid   = 1'b0;
        s_axi_bready   = 1'b0;
        s_axi_araddr   = '0;
        s_axi_arprot   = 3'b000;
        s_axi_arvalid  = 1'b0;
        s_axi_rready   = 1'b0;
        exp_valid      = 1'b0;
        exp_addr       = '0;
        exp_data       = '0;
        misc_errors    = 0;
        reads_expected = 0;
        cycle_limit    = 1000000;
        load_patterns();
        cycle_limit = (ZERO_WORDS + rec_kind.size()) * 20 + 2 * RUN_CYCLES + 2000;
        wait (s_axi_aresetn === 1'b1);
        @(posedge s_axi_aclk);
        // Buffer holds no reset value
        for (int w = 0; w < ZERO_WORDS; w++) begin
            axil_write(axil_addr_t'(`CA_ADDR_PSUM_BASE + 4 * w), '0);
        end
        run_records();
        repeat (4) @(posedge s_axi_aclk);
        if (rec_kind.size() == 0) begin
            $display("Pattern file holds no records");
            misc_errors++;
        end
        if (rd_checks != reads_expected) begin
            $display("Only %0d of %0d expected reads were compared", rd_checks, reads_expected);
            misc_errors++;
        end
        total = rd_errors + wr_errors + misc_errors;
        $display("Errors: %0d total, %0d read, %0d write, %0d other",
                 total, rd_errors, wr_errors, misc_errors);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (timed_out === 1'b1);
        $display("Errors: %0d read, %0d write, %0d other, run stopped by timeout",
                 rd_errors, wr_errors, misc_errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker import conv_acc_pkg::*; (
    input  logic       s_axi_aclk,
    input  logic       s_axi_awready,
    input  logic       s_axi_wready,
    input  logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    input  logic [1:0] s_axi_bresp,
    input  logic       s_axi_rvalid,
    input  logic       s_axi_rready,
    input  logic [1:0] s_axi_rresp,
    input  axil_data_t s_axi_rdata,
    input  logic       exp_valid,
    input  axil_addr_t exp_addr,
    input  axil_data_t exp_data,
    input  int         cycle_limit,
    output logic       timed_out,
    output int         rd_errors,
    output int         wr_errors,
    output int         rd_checks
);

    int cycles;

    initial begin
        cycles    = 0;
        timed_out = 1'b0;
        rd_errors = 0;
        wr_errors = 0;
        rd_checks = 0;
    end

    // ==============================
    // Response compare
    // ==============================
    // Handshake signals are stable at the falling edge
    always @(negedge s_axi_aclk) begin
        // Address and data ready pulse together
        if (s_axi_awready !== s_axi_wready) begin
            $display("FAIL @ %0t: AWREADY=%b and WREADY=%b differ",
                     $time, s_axi_awready, s_axi_wready);
            wr_errors++;
        end
        if (s_axi_bvalid && s_axi_bready && s_axi_bresp !== 2'b00) begin
            $display("FAIL @ %0t: write response BRESP=%b, expected OKAY", $time, s_axi_bresp);
            wr_errors++;
        end
        if (s_axi_rvalid && s_axi_rready) begin
            if (s_axi_rresp !== 2'b00) begin
                $display("FAIL @ %0t: read response RRESP=%b, expected OKAY",
                         $time, s_axi_rresp);
                rd_errors++;
            end
            if (exp_valid) begin
                rd_checks++;
                if (s_axi_rdata !== exp_data) begin
                    $display("FAIL @ %0t: read 0x%h returned 0x%h, expected 0x%h",
                             $time, exp_addr, s_axi_rdata, exp_data);
                    rd_errors++;
                end
            end
        end
    end

    // Cycle budget for the whole run
    always @(posedge s_axi_aclk) begin
        cycles++;
        if (cycles >= cycle_limit && !timed_out) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            timed_out = 1'b1;
        end
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
    output logic s_axi_aclk,
    output logic s_axi_aresetn
);

    // 4 ns period
    initial begin
        s_axi_aclk = 1'b0;
        forever #2 s_axi_aclk = ~s_axi_aclk;
    end

    // Reset held for 16 cycles, released on a rising edge
    initial begin
        s_axi_aresetn = 1'b0;
        repeat (16) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
    end

endmodule

// ==== conv_acc_top.sv ====
`timescale 1ns/10ps

module conv_acc_top import conv_acc_pkg::*; (
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    // Protection and strobes are not used, every write is a full word
    input  axil_addr_t s_axi_awaddr,
    input  logic [2:0] s_axi_awprot,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    input  axil_data_t s_axi_wdata,
    input  logic [3:0] s_axi_wstrb,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    input  axil_addr_t s_axi_araddr,
    input  logic [2:0] s_axi_arprot,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    output axil_data_t s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready
);

    psum_buf_if psum_bus ();
    acc_ctrl_if ctrl_bus ();

    // Output readback path
    onij_t      out_idx;
    lane_t      out_lane;
    axil_data_t out_word;

    axil_regs regs_i (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
        .psum(psum_bus.writer), .ctrl(ctrl_bus.host),
        .out_idx, .out_lane, .out_word
    );

    acc_sequencer seq_i (
        .s_axi_aclk, .s_axi_aresetn,
        .ctrl(ctrl_bus.engine), .psum(psum_bus.reader),
        .out_idx, .out_lane, .out_word
    );

    psum_buffer buf_i (.s_axi_aclk, .mem(psum_bus.mem));

endmodule

// ==== axil_regs.sv ====
`timescale 1ns/10ps
`include "conv_acc_macros.svh"

module axil_regs import conv_acc_pkg::*; (
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    input  axil_addr_t s_axi_awaddr,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    input  axil_data_t s_axi_wdata,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    input  axil_addr_t s_axi_araddr,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    output axil_data_t s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready,
    psum_buf_if.writer psum,
    acc_ctrl_if.host   ctrl,
    output onij_t      out_idx,
    output lane_t      out_lane,
    input  axil_data_t out_word
);

    localparam int PSUM_BYTES = `CA_LEN_KIJ * `CA_LEN_NIJ * (`CA_COL / 2) * 4;
    localparam int OUT_BYTES  = `CA_LEN_ONIJ * (`CA_COL / 2) * 4;

    logic       wr_ready;
    logic       wr_fire;
    logic       rd_fire;
    axil_addr_t awaddr_q;
    axil_addr_t araddr_q;
    axil_addr_t psum_off;
    axil_addr_t out_off;
    logic       psum_hit;
    logic       out_hit;
    axil_data_t rd_word;

    // ==============================
    // Write channel
    // ==============================
    assign wr_fire = wr_ready && s_axi_awvalid && s_axi_wvalid;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_ready     <= 1'b0;
            s_axi_bvalid <= 1'b0;
        end else begin
            wr_ready <= !wr_ready && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!wr_ready && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid) begin
            awaddr_q <= s_axi_awaddr;
        end
    end

    assign s_axi_awready = wr_ready;
    assign s_axi_wready  = wr_ready;
    assign s_axi_bresp   = 2'b00;

    // Start only when the engine is idle
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ctrl.start <= 1'b0;
        end else begin
            ctrl.start <= wr_fire && (awaddr_q == `CA_ADDR_CTRL) && s_axi_wdata[0]
                          && !ctrl.busy;
        end
    end

    // Psum window, four words per entry
    assign psum_off = awaddr_q - `CA_ADDR_PSUM_BASE;
    assign psum_hit = (awaddr_q >= `CA_ADDR_PSUM_BASE)
                      && (awaddr_q < `CA_ADDR_PSUM_BASE + PSUM_BYTES);

    assign psum.wr_en    = wr_fire && psum_hit && !ctrl.busy;
    assign psum.wr_entry = psum_off[$bits(entry_t)+3:4];
    assign psum.wr_lane  = psum_off[3:2];
    assign psum.wr_data  = s_axi_wdata;

    // ==============================
    // Read channel
    // ==============================
    assign rd_fire = s_axi_arready && s_axi_arvalid;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_arready <= !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
            if (rd_fire) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_arready && s_axi_arvalid && !s_axi_rvalid) begin
            araddr_q <= s_axi_araddr;
        end
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
        end
    end

    assign s_axi_rresp = 2'b00;

    // Output window, 16 bytes per output
    assign out_off  = araddr_q - `CA_ADDR_OUT_BASE;
    assign out_hit  = (araddr_q >= `CA_ADDR_OUT_BASE)
                      && (araddr_q < `CA_ADDR_OUT_BASE + OUT_BYTES);
    assign out_idx  = out_off[$bits(onij_t)+3:4];
    assign out_lane = out_off[3:2];

    always_comb begin
        if (araddr_q == `CA_ADDR_CTRL) begin
            rd_word = {29'b0, !ctrl.busy, ctrl.done, ctrl.busy};
        end else if (araddr_q == `CA_ADDR_STATUS) begin
            rd_word = {28'b0, ctrl.cur_onij};
        end else if (out_hit) begin
            rd_word = out_word;
        end else begin
            rd_word = `CA_BAD_READ;
        end
    end

endmodule

// ==== acc_sequencer.sv ====
`timescale 1ns/10ps
`include "conv_acc_macros.svh"

module acc_sequencer import conv_acc_pkg::*; (
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    acc_ctrl_if.engine ctrl,
    psum_buf_if.reader psum,
    input  onij_t      out_idx,
    input  lane_t      out_lane,
    output axil_data_t out_word
);

    typedef enum logic [2:0] {S_IDLE, S_CLEAR, S_READ, S_DRAIN, S_STORE} state_t;

    state_t     state;
    onij_t      onij;
    kij_t       kij;
    col_t       col;
    logic       done_q;
    logic       add_en;
    col_t       add_col;
    psum_t      acc [`CA_COL];
    psum_word_t out_regs [`CA_LEN_ONIJ];

    psum_addr_gen addr_i (.onij(onij), .kij(kij), .col(col), .entry(psum.rd_entry));

    assign psum.rd_en    = (state == S_READ);
    assign ctrl.busy     = (state != S_IDLE);
    assign ctrl.done     = done_q;
    assign ctrl.cur_onij = onij;

    // ==============================
    // Output, kernel and column loop
    // ==============================
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state  <= S_IDLE;
            onij   <= '0;
            kij    <= '0;
            col    <= '0;
            done_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (ctrl.start) begin
                        state  <= S_CLEAR;
                        onij   <= '0;
                        kij    <= '0;
                        col    <= '0;
                        done_q <= 1'b0;
                    end
                end
                S_CLEAR: state <= S_READ;
                S_READ: begin
                    col <= col + 1'b1;
                    if (col == col_t'(`CA_COL - 1)) begin
                        if (kij == kij_t'(`CA_LEN_KIJ - 1)) begin
                            kij   <= '0;
                            state <= S_DRAIN;
                        end else begin
                            kij <= kij + 1'b1;
                        end
                    end
                end
                // Last read lands in the accumulators here
                S_DRAIN: state <= S_STORE;
                S_STORE: begin
                    if (onij == onij_t'(`CA_LEN_ONIJ - 1)) begin
                        state  <= S_IDLE;
                        done_q <= 1'b1;
                    end else begin
                        onij  <= onij + 1'b1;
                        state <= S_CLEAR;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Column tag follows the read by one cycle
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            add_en <= 1'b0;
        end else begin
            add_en <= psum.rd_en;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        add_col <= col;
        if (state == S_CLEAR) begin
            for (int c = 0; c < `CA_COL; c++) begin
                acc[c] <= '0;
            end
        end else if (add_en) begin
            acc[add_col] <= acc[add_col] + psum.rd_data[add_col];
        end
    end

    // ReLU on store
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            for (int o = 0; o < `CA_LEN_ONIJ; o++) begin
                out_regs[o] <= '0;
            end
        end else if (state == S_STORE) begin
            for (int c = 0; c < `CA_COL; c++) begin
                out_regs[onij][c] <= acc[c][`CA_PSUM_BW-1] ? '0 : acc[c];
            end
        end
    end

    // Lane L holds columns 2L and 2L+1
    assign out_word = out_regs[out_idx][2*out_lane +: 2];

endmodule

// ==== psum_buffer.sv ====
`timescale 1ns/10ps
`include "conv_acc_macros.svh"

module psum_buffer import conv_acc_pkg::*; (
    input logic     s_axi_aclk,
    psum_buf_if.mem mem
);

    localparam int DEPTH = `CA_LEN_KIJ * `CA_LEN_NIJ;

    psum_word_t ram [DEPTH];

    // Lane write from the AXI-Lite window
    always_ff @(posedge s_axi_aclk) begin
        if (mem.wr_en) begin
            ram[mem.wr_entry][2*mem.wr_lane +: 2] <= mem.wr_data;
        end
    end

    // Registered read port
    always_ff @(posedge s_axi_aclk) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_entry];
        end
    end

endmodule

// ==== psum_addr_gen.sv ====
`timescale 1ns/10ps
`include "conv_acc_macros.svh"

module psum_addr_gen import conv_acc_pkg::*; (
    input  onij_t  onij,
    input  kij_t   kij,
    input  col_t   col,
    output entry_t entry
);

    logic [5:0] pad_pos;
    logic [6:0] skew_pos;

    // Output position and kernel offset mapped onto the padded input
    assign pad_pos = 6'((onij / `CA_OUT_DIM) * `CA_PAD_DIM + onij % `CA_OUT_DIM
                        + (kij / `CA_K_DIM) * `CA_PAD_DIM + kij % `CA_K_DIM);

    // Capture skew and column delay within one kernel block
    assign skew_pos = 7'(pad_pos + `CA_SKEW + col);

    assign entry = entry_t'(kij * `CA_LEN_NIJ + skew_pos % `CA_LEN_NIJ);

endmodule

// ==== conv_acc_if.sv ====
`timescale 1ns/10ps

// Partial-sum buffer port shared by the register block, the sequencer and the memory
interface psum_buf_if import conv_acc_pkg::*; ();
    logic       wr_en;
    entry_t     wr_entry;
    lane_t      wr_lane;
    axil_data_t wr_data;
    logic       rd_en;
    entry_t     rd_entry;
    psum_word_t rd_data;

    modport writer (output wr_en, wr_entry, wr_lane, wr_data);
    modport reader (output rd_en, rd_entry, input rd_data);
    modport mem (
        input  wr_en, wr_entry, wr_lane, wr_data,
        input  rd_en, rd_entry,
        output rd_data
    );
endinterface

// Run control between the register block and the sequencer
interface acc_ctrl_if import conv_acc_pkg::*; ();
    logic  start;
    logic  busy;
    logic  done;
    onij_t cur_onij;

    modport host (output start, input busy, done, cur_onij);
    modport engine (input start, output busy, done, cur_onij);
endinterface

// ==== conv_acc_pkg.sv ====
`include "conv_acc_macros.svh"

package conv_acc_pkg;

    // One column partial sum and one full buffer entry
    typedef logic signed [`CA_PSUM_BW-1:0] psum_t;
    typedef psum_t [`CA_COL-1:0] psum_word_t;

    // Buffer addressing
    typedef logic [$clog2(`CA_LEN_KIJ * `CA_LEN_NIJ)-1:0] entry_t;
    typedef logic [$clog2(`CA_COL / 2)-1:0] lane_t;

    // Sequencer indices
    typedef logic [$clog2(`CA_LEN_ONIJ)-1:0] onij_t;
    typedef logic [3:0] kij_t;
    typedef logic [$clog2(`CA_COL)-1:0] col_t;

    // AXI-Lite words
    typedef logic [`CA_AXI_ADDR_W-1:0] axil_addr_t;
    typedef logic [`CA_AXI_DATA_W-1:0] axil_data_t;

endpackage

// ==== conv_acc_macros.svh ====
`ifndef CONV_ACC_MACROS_SVH
`define CONV_ACC_MACROS_SVH

// Array and convolution geometry
`define CA_COL        8
`define CA_PSUM_BW    16
`define CA_LEN_NIJ    36
`define CA_LEN_KIJ    9
`define CA_LEN_ONIJ   16
`define CA_PAD_DIM    6
`define CA_OUT_DIM    4
`define CA_K_DIM      3
`define CA_SKEW       30

// AXI-Lite bus
`define CA_AXI_ADDR_W 14
`define CA_AXI_DATA_W 32

// Register map
`define CA_ADDR_CTRL      14'h0000
`define CA_ADDR_STATUS    14'h0004
`define CA_ADDR_OUT_BASE  14'h0100
`define CA_ADDR_PSUM_BASE 14'h2000
`define CA_BAD_READ       32'hDEADBEEF

`endif
